// ==== verilog/proc_pkg.sv ====
package proc_pkg;

    localparam int S_WIDTH    = 36;
    localparam int LANE_WIDTH = 32;
    localparam int LANES      = 4;
    localparam int S_REGS     = 16;
    localparam int V_REGS     = 8;
    localparam int SCALAR_LAT = 2;  // inst_valid sample to scalar writeback.
    localparam int VECTOR_LAT = 4;

    // instruction field positions.
    localparam int OPC_HI = 31;
    localparam int OPC_LO = 27;
    localparam int HL_BIT = 26;
    localparam int RD_HI  = 23;
    localparam int RD_LO  = 20;
    localparam int RS1_HI = 18;
    localparam int RS1_LO = 15;
    localparam int RS2_HI = 13;
    localparam int RS2_LO = 10;
    localparam int IMM_HI = 17;
    localparam int IMM_LO = 0;

    typedef logic [31:0]                 inst_t;
    typedef logic [S_WIDTH-1:0]          sword_t;
    typedef logic [LANE_WIDTH-1:0]       lane_t;
    typedef logic [LANES*LANE_WIDTH-1:0] vword_t;  // lane 0 in the low bits.
    typedef logic [3:0]                  sreg_addr_t;
    typedef logic [2:0]                  vreg_addr_t;
    typedef logic [IMM_HI-IMM_LO:0]      imm_t;

    typedef enum logic [OPC_HI-OPC_LO:0] {
        OP_NOP    = 5'd0,
        OP_ADD    = 5'd1,
        OP_SUB    = 5'd2,
        OP_AND    = 5'd3,
        OP_XOR    = 5'd4,
        OP_LI     = 5'd5,
        OP_VADD   = 5'd8,
        OP_VMUL   = 5'd9,
        OP_VBCAST = 5'd10
    } opcode_t;

endpackage

// ==== verilog/control_bus.sv ====
`timescale 1ns/1ps

interface control_bus;
    import proc_pkg::*;

    logic       valid;
    opcode_t    op;
    sreg_addr_t s_rd;
    vreg_addr_t v_rd;
    logic       hl;       // li targets the high half.
    logic       illegal;

    modport source (
        output valid,
        output op,
        output s_rd,
        output v_rd,
        output hl,
        output illegal
    );

    modport sink (
        input valid,
        input op,
        input s_rd,
        input v_rd,
        input hl,
        input illegal
    );

endinterface

// ==== verilog/control_pipeline.sv ====
`timescale 1ns/1ps

module control_pipeline #(
    parameter int DEPTH = 1
) (
    input  logic       clk,
    input  logic       rst_n,
    control_bus.sink   control_d,
    control_bus.source control_q
);
    import proc_pkg::*;

    logic       valid_r   [DEPTH];
    opcode_t    op_r      [DEPTH];
    sreg_addr_t s_rd_r    [DEPTH];
    vreg_addr_t v_rd_r    [DEPTH];
    logic       hl_r      [DEPTH];
    logic       illegal_r [DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                valid_r[i]   <= 1'b0;
                op_r[i]      <= OP_NOP;
                s_rd_r[i]    <= '0;
                v_rd_r[i]    <= '0;
                hl_r[i]      <= 1'b0;
                illegal_r[i] <= 1'b0;
            end
        end else begin
            valid_r[0]   <= control_d.valid;
            op_r[0]      <= control_d.op;
            s_rd_r[0]    <= control_d.s_rd;
            v_rd_r[0]    <= control_d.v_rd;
            hl_r[0]      <= control_d.hl;
            illegal_r[0] <= control_d.illegal;
            for (int i = 1; i < DEPTH; i++) begin
                valid_r[i]   <= valid_r[i-1];
                op_r[i]      <= op_r[i-1];
                s_rd_r[i]    <= s_rd_r[i-1];
                v_rd_r[i]    <= v_rd_r[i-1];
                hl_r[i]      <= hl_r[i-1];
                illegal_r[i] <= illegal_r[i-1];
            end
        end
    end

    assign control_q.valid   = valid_r[DEPTH-1];
    assign control_q.op      = op_r[DEPTH-1];
    assign control_q.s_rd    = s_rd_r[DEPTH-1];
    assign control_q.v_rd    = v_rd_r[DEPTH-1];
    assign control_q.hl      = hl_r[DEPTH-1];
    assign control_q.illegal = illegal_r[DEPTH-1];

endmodule

// ==== verilog/decode.sv ====
`timescale 1ns/1ps

module decode (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   inst_valid,
    input  proc_pkg::inst_t        inst,
    input  logic                   s_we,
    input  proc_pkg::sreg_addr_t   s_waddr,
    input  proc_pkg::sword_t       s_wdata,
    input  logic                   v_we,
    input  proc_pkg::vreg_addr_t   v_waddr,
    input  proc_pkg::vword_t       v_wdata,
    control_bus.source             s_ctrl,
    control_bus.source             v_ctrl,
    output proc_pkg::sword_t       sdata1,
    output proc_pkg::sword_t       sdata2,
    output proc_pkg::sword_t       sold,
    output proc_pkg::vword_t       vdata1,
    output proc_pkg::vword_t       vdata2,
    output proc_pkg::lane_t        bcast,
    output proc_pkg::imm_t         imm
);
    import proc_pkg::*;

    inst_t                 inst_d;
    logic                  inst_valid_d;
    sword_t                sregs [S_REGS];
    vword_t                vregs [V_REGS];
    logic [OPC_HI-OPC_LO:0] opc;
    sreg_addr_t            rd;
    sreg_addr_t            rs1;
    sreg_addr_t            rs2;
    opcode_t               op;
    logic                  is_scalar;
    logic                  is_vector;
    logic                  is_illegal;

    assign opc = inst_d[OPC_HI:OPC_LO];
    assign rd  = inst_d[RD_HI:RD_LO];
    assign rs1 = inst_d[RS1_HI:RS1_LO];
    assign rs2 = inst_d[RS2_HI:RS2_LO];

    always_comb begin
        op         = OP_NOP;
        is_scalar  = 1'b0;
        is_vector  = 1'b0;
        is_illegal = 1'b0;
        case (opc)
            OP_NOP: op = OP_NOP;
            OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_LI: begin
                op        = opcode_t'(opc);
                is_scalar = 1'b1;
            end
            OP_VADD, OP_VMUL, OP_VBCAST: begin
                op        = opcode_t'(opc);
                is_vector = 1'b1;
            end
            default: is_illegal = 1'b1;  // reported as err at writeback.
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_d       <= '0;
            inst_valid_d <= 1'b0;
        end else begin
            inst_d       <= inst;
            inst_valid_d <= inst_valid;
        end
    end

    // a write lands at the same edge that samples the read, so reads see the old value.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < S_REGS; i++) begin
                sregs[i] <= '0;
            end
            for (int i = 0; i < V_REGS; i++) begin
                vregs[i] <= '0;
            end
        end else begin
            if (s_we) sregs[s_waddr] <= s_wdata;
            if (v_we) vregs[v_waddr] <= v_wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_ctrl.valid   <= 1'b0;
            s_ctrl.op      <= OP_NOP;
            s_ctrl.s_rd    <= '0;
            s_ctrl.v_rd    <= '0;
            s_ctrl.hl      <= 1'b0;
            s_ctrl.illegal <= 1'b0;
            v_ctrl.valid   <= 1'b0;
            v_ctrl.op      <= OP_NOP;
            v_ctrl.s_rd    <= '0;
            v_ctrl.v_rd    <= '0;
            v_ctrl.hl      <= 1'b0;
            v_ctrl.illegal <= 1'b0;
            sdata1         <= '0;
            sdata2         <= '0;
            sold           <= '0;
            vdata1         <= '0;
            vdata2         <= '0;
            bcast          <= '0;
            imm            <= '0;
        end else begin
            s_ctrl.valid   <= inst_valid_d & (is_scalar | is_illegal);
            s_ctrl.op      <= op;
            s_ctrl.s_rd    <= rd;
            s_ctrl.v_rd    <= rd[2:0];
            s_ctrl.hl      <= inst_d[HL_BIT];
            s_ctrl.illegal <= is_illegal;
            v_ctrl.valid   <= inst_valid_d & is_vector;
            v_ctrl.op      <= op;
            v_ctrl.s_rd    <= rd;
            v_ctrl.v_rd    <= rd[2:0];
            v_ctrl.hl      <= inst_d[HL_BIT];
            v_ctrl.illegal <= 1'b0;
            sdata1         <= sregs[rs1];
            sdata2         <= sregs[rs2];
            sold           <= sregs[rd];  // old rd, for the li merge.
            vdata1         <= vregs[rs1[2:0]];
            vdata2         <= vregs[rs2[2:0]];
            bcast          <= sregs[rs1][LANE_WIDTH-1:0];
            imm            <= inst_d[IMM_HI:IMM_LO];
        end
    end

endmodule

// ==== verilog/scalar_execute.sv ====
`timescale 1ns/1ps

module scalar_execute (
    input  logic             clk,
    input  logic             rst_n,
    control_bus.sink         ctrl,
    input  proc_pkg::sword_t sdata1,
    input  proc_pkg::sword_t sdata2,
    input  proc_pkg::sword_t sold,
    input  proc_pkg::imm_t   imm,
    output proc_pkg::sword_t result,
    output proc_pkg::sword_t sold_w,
    output proc_pkg::imm_t   imm_w
);
    import proc_pkg::*;

    sword_t alu;

    // wraps modulo 2^36.
    always_comb begin
        case (ctrl.op)
            OP_ADD:  alu = sdata1 + sdata2;
            OP_SUB:  alu = sdata1 - sdata2;
            OP_AND:  alu = sdata1 & sdata2;
            OP_XOR:  alu = sdata1 ^ sdata2;
            default: alu = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
            sold_w <= '0;
            imm_w  <= '0;
        end else begin
            result <= alu;
            sold_w <= sold;  // li merge happens in writeback.
            imm_w  <= imm;
        end
    end

endmodule

// ==== verilog/vector_execute.sv ====
`timescale 1ns/1ps

module vector_execute (
    input  logic             clk,
    input  logic             rst_n,
    control_bus.sink         ctrl,
    input  proc_pkg::vword_t vdata1,
    input  proc_pkg::vword_t vdata2,
    input  proc_pkg::lane_t  bcast,
    output proc_pkg::vword_t result
);
    import proc_pkg::*;

    vword_t a_next;
    vword_t b_next;
    vword_t r_next;
    vword_t a_e1;
    vword_t b_e1;
    logic   mul_e1;
    vword_t r_e2;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            // broadcast rides the adder with a zero operand.
            if (ctrl.op == OP_VBCAST) begin
                a_next[i*LANE_WIDTH +: LANE_WIDTH] = bcast;
                b_next[i*LANE_WIDTH +: LANE_WIDTH] = '0;
            end else begin
                a_next[i*LANE_WIDTH +: LANE_WIDTH] = vdata1[i*LANE_WIDTH +: LANE_WIDTH];
                b_next[i*LANE_WIDTH +: LANE_WIDTH] = vdata2[i*LANE_WIDTH +: LANE_WIDTH];
            end
            if (mul_e1) begin
                r_next[i*LANE_WIDTH +: LANE_WIDTH] = a_e1[i*LANE_WIDTH +: LANE_WIDTH]
                                                   * b_e1[i*LANE_WIDTH +: LANE_WIDTH];
            end else begin
                r_next[i*LANE_WIDTH +: LANE_WIDTH] = a_e1[i*LANE_WIDTH +: LANE_WIDTH]
                                                   + b_e1[i*LANE_WIDTH +: LANE_WIDTH];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_e1   <= '0;
            b_e1   <= '0;
            mul_e1 <= 1'b0;
            r_e2   <= '0;
            result <= '0;
        end else begin
            a_e1   <= a_next;       // e1.
            b_e1   <= b_next;
            mul_e1 <= (ctrl.op == OP_VMUL);
            r_e2   <= r_next;       // e2, low 32 bits per lane.
            result <= r_e2;         // e3.
        end
    end

endmodule

// ==== verilog/writeback.sv ====
`timescale 1ns/1ps

module writeback (
    control_bus.sink               s_ctrl,
    control_bus.sink               v_ctrl,
    input  proc_pkg::sword_t       s_result,
    input  proc_pkg::sword_t       sold,
    input  proc_pkg::imm_t         imm,
    input  proc_pkg::vword_t       v_result,
    output logic                   s_we,
    output proc_pkg::sreg_addr_t   s_waddr,
    output proc_pkg::sword_t       s_wdata,
    output logic                   v_we,
    output proc_pkg::vreg_addr_t   v_waddr,
    output proc_pkg::vword_t       v_wdata,
    output logic                   err
);
    import proc_pkg::*;

    always_comb begin
        if (s_ctrl.op == OP_LI) begin
            // the half not named by hl keeps its old value.
            if (s_ctrl.hl) s_wdata = {imm, sold[S_WIDTH/2-1:0]};
            else           s_wdata = {sold[S_WIDTH-1:S_WIDTH/2], imm};
        end else begin
            s_wdata = s_result;
        end
    end

    assign s_we    = s_ctrl.valid & ~s_ctrl.illegal;
    assign err     = s_ctrl.valid & s_ctrl.illegal;  // no register write on err.
    assign s_waddr = s_ctrl.s_rd;

    assign v_we    = v_ctrl.valid;
    assign v_waddr = v_ctrl.v_rd;
    assign v_wdata = v_result;

endmodule

// ==== verilog/proc.sv ====
`timescale 1ns/1ps

module proc (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 inst_valid,
    input  proc_pkg::inst_t      inst,
    output logic                 s_wb_valid,
    output proc_pkg::sreg_addr_t s_wb_addr,
    output proc_pkg::sword_t     s_wb_data,
    output logic                 v_wb_valid,
    output proc_pkg::vreg_addr_t v_wb_addr,
    output proc_pkg::vword_t     v_wb_data,
    output logic                 err
);
    import proc_pkg::*;

    control_bus s_ctrl_e ();
    control_bus s_ctrl_w ();
    control_bus v_ctrl_e ();
    control_bus v_ctrl_w ();

    sword_t sdata1;
    sword_t sdata2;
    sword_t sold;
    vword_t vdata1;
    vword_t vdata2;
    lane_t  bcast;
    imm_t   imm;
    sword_t s_result_w;
    sword_t sold_w;
    imm_t   imm_w;
    vword_t v_result_w;

    // writeback ports go to the register files and straight out.
    decode i_decode (
        .clk(clk), .rst_n(rst_n), .inst_valid(inst_valid), .inst(inst),
        .s_we(s_wb_valid), .s_waddr(s_wb_addr), .s_wdata(s_wb_data),
        .v_we(v_wb_valid), .v_waddr(v_wb_addr), .v_wdata(v_wb_data),
        .s_ctrl(s_ctrl_e), .v_ctrl(v_ctrl_e),
        .sdata1(sdata1), .sdata2(sdata2), .sold(sold),
        .vdata1(vdata1), .vdata2(vdata2), .bcast(bcast), .imm(imm)
    );

    scalar_execute i_scalar_execute (
        .clk(clk), .rst_n(rst_n), .ctrl(s_ctrl_e),
        .sdata1(sdata1), .sdata2(sdata2), .sold(sold), .imm(imm),
        .result(s_result_w), .sold_w(sold_w), .imm_w(imm_w)
    );

    vector_execute i_vector_execute (
        .clk(clk), .rst_n(rst_n), .ctrl(v_ctrl_e),
        .vdata1(vdata1), .vdata2(vdata2), .bcast(bcast), .result(v_result_w)
    );

    control_pipeline #(.DEPTH(1)) i_s_ctrl_pipe (
        .clk(clk), .rst_n(rst_n), .control_d(s_ctrl_e), .control_q(s_ctrl_w)
    );

    control_pipeline #(.DEPTH(3)) i_v_ctrl_pipe (  // matches e1 to e3.
        .clk(clk), .rst_n(rst_n), .control_d(v_ctrl_e), .control_q(v_ctrl_w)
    );

    writeback i_writeback (
        .s_ctrl(s_ctrl_w), .v_ctrl(v_ctrl_w),
        .s_result(s_result_w), .sold(sold_w), .imm(imm_w), .v_result(v_result_w),
        .s_we(s_wb_valid), .s_waddr(s_wb_addr), .s_wdata(s_wb_data),
        .v_we(v_wb_valid), .v_waddr(v_wb_addr), .v_wdata(v_wb_data),
        .err(err)
    );

endmodule

// ==== tests/proc_assertions.sv ====
`timescale 1ns/1ps

module proc_assertions (
    input logic            clk,
    input logic            rst_n,
    input logic            inst_valid,
    input proc_pkg::inst_t inst,
    input logic            s_wb_valid,
    input logic            v_wb_valid,
    input logic            err
);
    import proc_pkg::*;

    logic [OPC_HI-OPC_LO:0] opc;
    logic                   scalar_issue;
    logic                   vector_issue;
    int                     failures = 0;

    assign opc          = inst[OPC_HI:OPC_LO];
    assign scalar_issue = inst_valid && (opc inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_LI});
    assign vector_issue = inst_valid && (opc inside {OP_VADD, OP_VMUL, OP_VBCAST});

    a_write_or_err: assert property (@(posedge clk) disable iff (!rst_n)
        !(s_wb_valid && err))
        else begin
            failures++;
            $error("s_wb_valid and err high in the same cycle");
        end

    a_quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> !(s_wb_valid || v_wb_valid || err))
        else begin
            failures++;
            $error("writeback output high during reset");
        end

    // outputs are visible after edge k+LAT, so they are sampled one edge later.
    a_scalar_latency: assert property (@(posedge clk) disable iff (!rst_n)
        scalar_issue |-> ##(SCALAR_LAT + 1) s_wb_valid)
        else begin
            failures++;
            $error("s_wb_valid missing after a scalar issue");
        end

    a_vector_latency: assert property (@(posedge clk) disable iff (!rst_n)
        vector_issue |-> ##(VECTOR_LAT + 1) v_wb_valid)
        else begin
            failures++;
            $error("v_wb_valid missing after a vector issue");
        end

endmodule

bind proc proc_assertions i_proc_assertions (
    .clk(clk), .rst_n(rst_n), .inst_valid(inst_valid), .inst(inst),
    .s_wb_valid(s_wb_valid), .v_wb_valid(v_wb_valid), .err(err)
);

// ==== tests/proc_tb.sv ====
`timescale 1ns/1ps

module proc_tb;
    import proc_pkg::*;

    typedef struct packed {
        logic       is_err;
        sreg_addr_t addr;
        sword_t     data;
        int         due;
    } s_exp_t;

    typedef struct packed {
        vreg_addr_t addr;
        vword_t     data;
        int         due;
    } v_exp_t;

    localparam int N_LI    = 2 * S_REGS;
    localparam int N_ALU   = 40;
    localparam int N_BCAST = V_REGS;
    localparam int N_VEC   = 40;
    localparam int N_MIX   = 60;
    localparam int N_ILL   = 12;
    localparam int N_NOP   = 10;
    localparam int TOTAL   = N_LI + N_ALU + N_BCAST + N_VEC + N_MIX + 2 * N_ILL + N_NOP;
    localparam int TIMEOUT = TOTAL * (VECTOR_LAT + 8) + 100;
    localparam opcode_t MIX_OPS [8] = '{OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_LI,
                                        OP_VADD, OP_VMUL, OP_VBCAST};

    logic       clk;
    logic       rst_n;
    logic       inst_valid;
    inst_t      inst;
    logic       s_wb_valid;
    sreg_addr_t s_wb_addr;
    sword_t     s_wb_data;
    logic       v_wb_valid;
    vreg_addr_t v_wb_addr;
    vword_t     v_wb_data;
    logic       err;

    logic [31:0] lfsr = 32'h4d4ea659;
    sword_t      sh_s   [S_REGS];  // shadow files updated at issue.
    vword_t      sh_v   [V_REGS];
    logic        pend_s [S_REGS];
    logic        pend_v [V_REGS];
    s_exp_t      s_q [$];
    v_exp_t      v_q [$];
    int          cycle = 0;
    int          checks = 0;
    int          errors = 0;
    int          errors_at_start = 0;
    int          issued = 0;
    int          test_no = 0;

    proc i_proc (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        wait (cycle > TIMEOUT);
        $display("run stopped by the timeout after %0d cycles", cycle);
        $display("TESTS FAILED");
        $finish;
    end

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic inst_t gen_inst(input logic [4:0] opc);
        inst_t w;
        w = rand_bits(32);
        w[OPC_HI:OPC_LO] = opc;
        return w;
    endfunction

    function automatic logic is_legal(input logic [4:0] opc);
        return opc inside {OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_LI,
                           OP_VADD, OP_VMUL, OP_VBCAST};
    endfunction

    function automatic logic blocked(input inst_t w);
        sreg_addr_t rd;
        sreg_addr_t rs1;
        sreg_addr_t rs2;
        rd  = w[RD_HI:RD_LO];
        rs1 = w[RS1_HI:RS1_LO];
        rs2 = w[RS2_HI:RS2_LO];
        case (w[OPC_HI:OPC_LO])
            OP_ADD, OP_SUB, OP_AND, OP_XOR: return pend_s[rd] | pend_s[rs1] | pend_s[rs2];
            OP_LI:            return pend_s[rd];  // the other half is kept.
            OP_VADD, OP_VMUL: return pend_v[rd[2:0]] | pend_v[rs1[2:0]] | pend_v[rs2[2:0]];
            OP_VBCAST:        return pend_v[rd[2:0]] | pend_s[rs1];
            default:          return 1'b0;
        endcase
    endfunction

    task automatic check_sword(input string name, input sword_t exp, input sword_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_vword(input string name, input vword_t exp, input vword_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic expect_scalar(input logic is_err, input sreg_addr_t addr, input sword_t data);
        s_exp_t e;
        e.is_err = is_err;
        e.addr   = addr;
        e.data   = data;
        e.due    = cycle + SCALAR_LAT + 2;  // counted in negedges from the drive.
        s_q.push_back(e);
        if (!is_err) begin
            sh_s[addr]   = data;
            pend_s[addr] = 1'b1;
        end
    endtask

    task automatic expect_vector(input vreg_addr_t addr, input vword_t data);
        v_exp_t e;
        e.addr = addr;
        e.data = data;
        e.due  = cycle + VECTOR_LAT + 2;
        v_q.push_back(e);
        sh_v[addr]   = data;
        pend_v[addr] = 1'b1;
    endtask

    task automatic idle();
        @(posedge clk);
        inst_valid <= 1'b0;
        inst       <= rand_bits(32);  // junk on the bus must be ignored.
    endtask

    task automatic issue(input inst_t w);
        logic [4:0]  opc;
        sreg_addr_t  rd;
        sreg_addr_t  rs1;
        sreg_addr_t  rs2;
        imm_t        imm;
        sword_t      old;
        vword_t      r;
        lane_t       a;
        lane_t       b;
        logic [63:0] prod;
        opc = w[OPC_HI:OPC_LO];
        rd  = w[RD_HI:RD_LO];
        rs1 = w[RS1_HI:RS1_LO];
        rs2 = w[RS2_HI:RS2_LO];
        imm = w[IMM_HI:IMM_LO];
        while (blocked(w)) idle();
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= w;
        issued++;
        old = sh_s[rd];
        case (opc)
            OP_NOP: ;
            OP_ADD: expect_scalar(1'b0, rd, sh_s[rs1] + sh_s[rs2]);
            OP_SUB: expect_scalar(1'b0, rd, sh_s[rs1] - sh_s[rs2]);
            OP_AND: expect_scalar(1'b0, rd, sh_s[rs1] & sh_s[rs2]);
            OP_XOR: expect_scalar(1'b0, rd, sh_s[rs1] ^ sh_s[rs2]);
            OP_LI: begin
                if (w[HL_BIT]) expect_scalar(1'b0, rd, {imm, old[17:0]});
                else expect_scalar(1'b0, rd, {old[35:18], imm});
            end
            OP_VADD, OP_VMUL, OP_VBCAST: begin
                for (int i = 0; i < LANES; i++) begin
                    a    = sh_v[rs1[2:0]][i*LANE_WIDTH +: LANE_WIDTH];
                    b    = sh_v[rs2[2:0]][i*LANE_WIDTH +: LANE_WIDTH];
                    prod = 64'(a) * 64'(b);
                    if (opc == OP_VADD) r[i*LANE_WIDTH +: LANE_WIDTH] = a + b;
                    else if (opc == OP_VMUL) r[i*LANE_WIDTH +: LANE_WIDTH] = prod[31:0];
                    else r[i*LANE_WIDTH +: LANE_WIDTH] = sh_s[rs1][31:0];
                end
                expect_vector(rd[2:0], r);
            end
            default: expect_scalar(1'b1, rd, '0);  // err leaves the files untouched.
        endcase
    endtask

    task automatic check_scalar_port();
        s_exp_t e;
        if (s_wb_valid || err) begin
            if (s_q.size() == 0) begin
                errors++;
                $display("%0t: scalar writeback or err pulse with nothing outstanding", $time);
            end else begin
                e = s_q.pop_front();
                if (e.due != cycle) begin
                    errors++;
                    $display("%0t: scalar pulse came in cycle %0d instead of %0d",
                             $time, cycle, e.due);
                end
                check_flag("err", e.is_err, err);
                check_flag("s_wb_valid", !e.is_err, s_wb_valid);
                if (!e.is_err) begin
                    check_sword("s_wb_addr", sword_t'(e.addr), sword_t'(s_wb_addr));
                    check_sword("s_wb_data", e.data, s_wb_data);
                    pend_s[e.addr] = 1'b0;
                end
            end
        end else if (s_q.size() != 0 && s_q[0].due <= cycle) begin
            e = s_q.pop_front();
            errors++;
            $display("%0t: expected scalar pulse for r%0d never arrived", $time, e.addr);
            if (!e.is_err) pend_s[e.addr] = 1'b0;
        end
    endtask

    task automatic check_vector_port();
        v_exp_t e;
        if (v_wb_valid) begin
            if (v_q.size() == 0) begin
                errors++;
                $display("%0t: vector writeback pulse with nothing outstanding", $time);
            end else begin
                e = v_q.pop_front();
                if (e.due != cycle) begin
                    errors++;
                    $display("%0t: vector pulse came in cycle %0d instead of %0d",
                             $time, cycle, e.due);
                end
                check_sword("v_wb_addr", sword_t'(e.addr), sword_t'(v_wb_addr));
                check_vword("v_wb_data", e.data, v_wb_data);
                pend_v[e.addr] = 1'b0;
            end
        end else if (v_q.size() != 0 && v_q[0].due <= cycle) begin
            e = v_q.pop_front();
            errors++;
            $display("%0t: expected vector pulse for v%0d never arrived", $time, e.addr);
            pend_v[e.addr] = 1'b0;
        end
    endtask

    // outputs settle half a cycle after the edge.
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (rst_n) begin
            check_scalar_port();
            check_vector_port();
        end
    end

    task automatic end_test(input string name);
        do idle(); while (s_q.size() != 0 || v_q.size() != 0);
        repeat (4) idle();  // room for a stray pulse.
        test_no++;
        $display("test %0d (%s) finished with %0d errors", test_no, name,
                 errors - errors_at_start);
        errors_at_start = errors;
    endtask

    initial begin
        inst_t      w;
        logic [4:0] opc;
        sreg_addr_t ill_rd;
        int         fails;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        for (int i = 0; i < S_REGS; i++) begin
            sh_s[i]   = '0;
            pend_s[i] = 1'b0;
        end
        for (int i = 0; i < V_REGS; i++) begin
            sh_v[i]   = '0;
            pend_v[i] = 1'b0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        repeat (10) idle();
        end_test("reset and idle");

        for (int i = 0; i < N_LI; i++) begin
            w = gen_inst(OP_LI);
            w[RD_HI:RD_LO] = sreg_addr_t'(i / 2);
            w[HL_BIT]      = i[0];  // low half first and then the high half.
            issue(w);
        end
        for (int i = 0; i < N_ALU; i++) issue(gen_inst(MIX_OPS[3'(rand_bits(2))]));
        end_test("scalar li and alu");

        for (int i = 0; i < N_BCAST; i++) begin
            w = gen_inst(OP_VBCAST);
            w[RD_HI:RD_LO] = sreg_addr_t'(i);
            issue(w);
        end
        for (int i = 0; i < N_VEC; i++) issue(gen_inst(MIX_OPS[3'(5 + rand_bits(1))]));
        end_test("vector broadcast, add and mul");

        for (int i = 0; i < N_MIX; i++) issue(gen_inst(MIX_OPS[3'(rand_bits(3))]));
        end_test("mixed scalar and vector");

        for (int i = 0; i < N_ILL; i++) begin
            do opc = 5'(rand_bits(5)); while (is_legal(opc));
            w      = gen_inst(opc);
            ill_rd = w[RD_HI:RD_LO];
            issue(w);
            w = gen_inst(MIX_OPS[3'(rand_bits(2))]);
            w[RS1_HI:RS1_LO] = ill_rd;  // reads back the register the illegal word named.
            issue(w);
        end
        end_test("illegal opcodes");

        for (int i = 0; i < N_NOP; i++) issue(gen_inst(OP_NOP));
        end_test("nop");

        fails = i_proc.i_proc_assertions.failures;
        $display("%0d instructions, %0d checks, %0d errors, %0d assertion failures",
                 issued, checks, errors, fails);
        if (errors == 0 && fails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
verilog/proc_pkg.sv
verilog/control_bus.sv
verilog/control_pipeline.sv
verilog/decode.sv
verilog/scalar_execute.sv
verilog/vector_execute.sv
verilog/writeback.sv
verilog/proc.sv
tests/proc_assertions.sv
tests/proc_tb.sv

// ==== Makefile ====
TOOL       := verilator
TOP        := proc_tb
FILELIST   := compile.f
BUILD      := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
RUN_ARGS   := +verilator+error+limit+100
SOURCES    := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(SOURCES) $(FILELIST)
	$(TOOL) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD) -o V$(TOP)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	grep -qx "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
